// ==== rtl/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ALU operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

    //////////////////////////////////////////////////////////////////////
    // Instruction formats
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    // One word, two views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_word_t;

    //////////////////////////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [ALU_OP_W-1:0]   alu_op;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
    } decoded_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file import rv_core_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [REG_ADDR_W-1:0] rs1,
    input  wire logic [REG_ADDR_W-1:0] rs2,
    input  wire wb_t                   wr,
    output logic      [XLEN-1:0]       rs1_data,
    output logic      [XLEN-1:0]       rs2_data
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    // Shared read path, write data bypasses the array
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr.valid && (wr.rd == addr)) begin
            return wr.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

`default_nettype wire

// ==== rtl/decoding_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoding_stage import rv_core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        instr_valid,
    input  wire instr_word_t instr,
    input  wire wb_t         wb,
    output decoded_t         dec
);

    decoded_t              dec_next;
    logic                  known_op;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;

    register_file u_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1_addr),
        .rs2      (rs2_addr),
        .wr       (wb),
        .rs1_data (rs1_rdata),
        .rs2_data (rs2_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        known_op = 1'b1;
        rs1_addr = instr.r.rs1;
        rs2_addr = instr.r.rs2;
        dec_next = '0;
        // Sign-extended I immediate by default
        dec_next.imm     = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
        dec_next.use_imm = 1'b1;

        case (instr.r.opcode)
            OPC_OP: begin
                dec_next.use_imm = 1'b0;
                case (instr.r.funct3)
                    3'b000:  dec_next.alu_op = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  dec_next.alu_op = ALU_SLL;
                    3'b010:  dec_next.alu_op = ALU_SLT;
                    3'b011:  dec_next.alu_op = ALU_SLTU;
                    3'b100:  dec_next.alu_op = ALU_XOR;
                    3'b101:  dec_next.alu_op = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  dec_next.alu_op = ALU_OR;
                    default: dec_next.alu_op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                case (instr.i.funct3)
                    3'b000:  dec_next.alu_op = ALU_ADD;
                    3'b001:  dec_next.alu_op = ALU_SLL;
                    3'b010:  dec_next.alu_op = ALU_SLT;
                    3'b011:  dec_next.alu_op = ALU_SLTU;
                    3'b100:  dec_next.alu_op = ALU_XOR;
                    // SRAI carries funct7 in the upper immediate bits
                    3'b101:  dec_next.alu_op = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  dec_next.alu_op = ALU_OR;
                    default: dec_next.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                rs1_addr         = '0;
                rs2_addr         = '0;
                dec_next.alu_op  = ALU_PASS_B;
                dec_next.imm     = {instr[31:12], 12'b0};
            end
            default: known_op = 1'b0;
        endcase

        dec_next.we       = instr_valid && known_op && (instr.r.rd != '0);
        dec_next.rd       = instr.r.rd;
        dec_next.rs1      = rs1_addr;
        dec_next.rs2      = rs2_addr;
        dec_next.rs1_data = rs1_rdata;
        dec_next.rs2_data = rs2_rdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
        end else begin
            dec <= dec_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/forwarding_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module forwarding_unit import rv_core_pkg::*; (
    input  wire decoded_t        dec,
    input  wire wb_t             wb,
    output logic     [XLEN-1:0]  op_a,
    output logic     [XLEN-1:0]  op_b
);

    logic hit_a;
    logic hit_b;

    // Only the write-back register can be newer than the stored operands;
    // anything older has already gone through the register file
    assign hit_a = wb.valid && (wb.rd == dec.rs1);
    assign hit_b = wb.valid && (wb.rd == dec.rs2);

    always_comb begin
        op_a = dec.rs1_data;
        op_b = dec.rs2_data;
        if (hit_a) begin
            op_a = wb.data;
        end
        if (hit_b) begin
            op_b = wb.data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/execution_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execution_stage import rv_core_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire decoded_t        dec,
    input  wire logic [XLEN-1:0] op_a,
    input  wire logic [XLEN-1:0] op_b,
    output wb_t                  wb
);

    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_out;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    // Second operand is the register or the immediate
    assign alu_b = dec.use_imm ? dec.imm : op_b;
    assign shamt = alu_b[4:0];

    assign lt_signed   = $signed(op_a) < $signed(alu_b);
    assign lt_unsigned = op_a < alu_b;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_out = op_a + alu_b;
            ALU_SUB:    alu_out = op_a - alu_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    alu_out = op_a ^ alu_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_out = op_a | alu_b;
            ALU_AND:    alu_out = op_a & alu_b;
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Write-back register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= dec.we;
            wb.rd    <= dec.rd;
            wb.data  <= alu_out;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        instr_valid,
    input  wire instr_word_t instr,
    output wb_t              wb
);

    // Decode to forwarding and execute
    decoded_t        dec;

    // Forwarded operands
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    decoding_stage u_decoding_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb),
        .dec         (dec)
    );

    forwarding_unit u_forwarding_unit (
        .dec  (dec),
        .wb   (wb),
        .op_a (op_a),
        .op_b (op_b)
    );

    execution_stage u_execution_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec),
        .op_a  (op_a),
        .op_b  (op_b),
        .wb    (wb)
    );

endmodule

`default_nettype wire

// ==== test/tb_rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int DIRECTED_SLOTS = 40;
    localparam int RANDOM_SLOTS   = 300;
    localparam int SLOT_COUNT     = DIRECTED_SLOTS + RANDOM_SLOTS;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    instr_word_t     instr;
    wb_t             wb;

    logic [XLEN-1:0] model_regs [0:31];
    logic [31:0]     lfsr_state;
    wb_t             exp_in;
    wb_t             exp_d1;
    wb_t             exp_d2;

    rv_core uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Random bits and instruction encoding
    //////////////////////////////////////////////////////////////////////

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic instr_word_t r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_word_t i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_word_t lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // Registers x0..x7 only, so that dependencies are frequent
    function automatic instr_word_t random_instr();
        logic [2:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        sel = 3'(take_bits(3));
        rd  = 5'(take_bits(3));
        rs1 = 5'(take_bits(3));
        rs2 = 5'(take_bits(3));
        f3  = 3'(take_bits(3));
        alt = 1'(take_bits(1));
        imm = 12'(take_bits(12));
        if (sel < 3) begin
            return r_type_word((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                               rs2, rs1, f3, rd);
        end else if (sel < 6) begin
            if (f3 == 3'd1) imm[11:5] = 7'h00;
            if (f3 == 3'd5) imm[11:5] = alt ? 7'h20 : 7'h00;
            return i_type_word(imm, rs1, f3, rd);
        end else if (sel == 6) begin
            return lui_word(20'(take_bits(20)), rd);
        end
        // Load and branch opcodes are unknown to this core
        return {imm, rs1, f3, rd, alt ? 7'b0000011 : 7'b1100011};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [XLEN-1:0] shift_right_arith(input logic [XLEN-1:0] v,
                                                          input logic [4:0] sh);
        return (v >> sh) | (v[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
    endfunction

    function automatic wb_t reference_result(input instr_word_t w);
        wb_t             res;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            known;
        a     = model_regs[w.r.rs1];
        b     = model_regs[w.r.rs2];
        known = 1'b1;
        res   = '0;
        // OP and OP_IMM share the ALU set but not the second operand
        if (w.r.opcode == OPC_OP_IMM) begin
            b = {{20{w.i.imm[11]}}, w.i.imm};
        end
        case (w.r.opcode)
            OPC_OP, OPC_OP_IMM: begin
                case (w.r.funct3)
                    3'd0: res.data = (w.r.opcode == OPC_OP && w.r.funct7[5]) ? a - b : a + b;
                    3'd1: res.data = a << b[4:0];
                    3'd2: res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd3: res.data = (a < b) ? 32'd1 : 32'd0;
                    3'd4: res.data = a ^ b;
                    3'd5: res.data = w.r.funct7[5] ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
                    3'd6: res.data = a | b;
                    default: res.data = a & b;
                endcase
            end
            OPC_LUI: res.data = {w[31:12], 12'b0};
            default: known = 1'b0;
        endcase
        res.valid = known && (w.r.rd != 5'd0);
        res.rd    = w.r.rd;
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic send_instr(input instr_word_t w);
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid = 1'b1;
        instr       = w;
        exp_in      = reference_result(w);
        if (exp_in.valid) model_regs[exp_in.rd] = exp_in.data;
    endtask

    task automatic send_gap(input instr_word_t w);
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid = 1'b0;
        instr       = w;
        exp_in      = '0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("FAIL time=%0t signal=%s got=0x%08h expected=0x%08h",
                 $time, name, got, expected);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_wb(input wb_t actual, input wb_t expected);
        if (expected.valid) begin
            if (actual.valid !== 1'b1) report_mismatch("wb.valid", actual.valid, 1);
            if (actual.rd !== expected.rd) report_mismatch("wb.rd", actual.rd, expected.rd);
            if (actual.data !== expected.data) begin
                report_mismatch("wb.data", actual.data, expected.data);
            end
        end else if (actual.valid !== 1'b0) begin
            report_mismatch("wb.valid", actual.valid, 0);
        end
    endtask

    // Two-edge delay line from issue to write-back
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_d1 <= '0;
            exp_d2 <= '0;
        end else begin
            exp_d1 <= exp_in;
            exp_d2 <= exp_d1;
        end
    end

    always @(negedge clk) begin
        if (rst_n) check_wb(wb, exp_d2);
    end

    initial begin
        #((SLOT_COUNT + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin
        instr_word_t w;
        logic [1:0]  gap;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        exp_in      = '0;
        lfsr_state  = 32'd53;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // Idle after reset
        repeat (3) send_gap('0);

        // Operand setup with back-to-back dependencies
        send_instr(lui_word(20'h80000, 5'd1));
        send_instr(i_type_word(12'hffb, 5'd1, 3'd0, 5'd1));
        send_instr(lui_word(20'h12345, 5'd2));
        send_instr(i_type_word(12'h678, 5'd2, 3'd0, 5'd2));
        send_instr(i_type_word(12'hffd, 5'd0, 3'd0, 5'd3));

        // Register-register operations
        send_instr(r_type_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd4));
        send_instr(r_type_word(7'h20, 5'd3, 5'd1, 3'd0, 5'd5));
        send_instr(r_type_word(7'h00, 5'd3, 5'd2, 3'd1, 5'd6));
        send_instr(r_type_word(7'h00, 5'd1, 5'd3, 3'd2, 5'd7));
        send_instr(r_type_word(7'h00, 5'd1, 5'd3, 3'd3, 5'd7));
        send_instr(r_type_word(7'h00, 5'd2, 5'd1, 3'd4, 5'd4));
        send_instr(r_type_word(7'h00, 5'd2, 5'd3, 3'd5, 5'd5));
        send_instr(r_type_word(7'h20, 5'd2, 5'd3, 3'd5, 5'd6));
        send_instr(r_type_word(7'h00, 5'd3, 5'd1, 3'd6, 5'd7));
        send_instr(r_type_word(7'h00, 5'd3, 5'd2, 3'd7, 5'd4));

        // Immediate operations and SRAI against SRLI
        send_instr(i_type_word(12'h800, 5'd3, 3'd0, 5'd5));
        send_instr(i_type_word(12'hfff, 5'd3, 3'd2, 5'd6));
        send_instr(i_type_word(12'hfff, 5'd3, 3'd3, 5'd7));
        send_instr(i_type_word(12'hfff, 5'd1, 3'd4, 5'd4));
        send_instr(i_type_word(12'h0f0, 5'd2, 3'd6, 5'd5));
        send_instr(i_type_word(12'h7ff, 5'd3, 3'd7, 5'd6));
        send_instr(i_type_word(12'h004, 5'd2, 3'd1, 5'd7));
        send_instr(i_type_word(12'h004, 5'd3, 3'd5, 5'd4));
        send_instr(i_type_word(12'h404, 5'd3, 3'd5, 5'd5));
        send_instr(i_type_word(12'h41f, 5'd1, 3'd5, 5'd6));

        // Forwarding one back and write-through two back
        send_instr(i_type_word(12'h001, 5'd6, 3'd0, 5'd7));
        send_instr(i_type_word(12'd100, 5'd0, 3'd0, 5'd1));
        send_instr(i_type_word(12'd200, 5'd0, 3'd0, 5'd2));
        send_instr(r_type_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        send_gap('0);
        send_instr(r_type_word(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));

        // No write for x0 or an unknown opcode
        send_instr(i_type_word(12'h005, 5'd1, 3'd0, 5'd0));
        send_instr({12'h000, 5'd1, 3'd0, 5'd3, 7'b0000011});
        send_instr(r_type_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd5));
        send_instr(r_type_word(7'h00, 5'd0, 5'd3, 3'd0, 5'd6));

        for (int n = 0; n < RANDOM_SLOTS; n++) begin
            gap = 2'(take_bits(2));
            w   = random_instr();
            if (gap == 2'd0) begin
                send_gap(w);
            end else begin
                send_instr(w);
            end
        end
        send_gap('0);
        repeat (4) @(posedge clk);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/rv_core_pkg.sv
rtl/register_file.sv
rtl/decoding_stage.sv
rtl/forwarding_unit.sv
rtl/execution_stage.sv
rtl/rv_core.sv
test/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rtl/rv_core_pkg.sv
  - rtl/register_file.sv
  - rtl/decoding_stage.sv
  - rtl/forwarding_unit.sv
  - rtl/execution_stage.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - test/tb_rv_core.sv
